//--- rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int ADDR_WIDTH     = 8;

  // instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  // unlisted codes decode as nop
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_SLT  = 6'd5,
    OP_ADDI = 6'd8,
    OP_LW   = 6'd9,
    OP_SW   = 6'd10,
    OP_BEQ  = 6'd12,
    OP_HALT = 6'd63
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

endpackage

//--- rtl/program_loader.sv
`timescale 1ns/100ps

module program_loader
  import cpu_pkg::*;
#(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   prog_valid,
  input  logic [INSTR_WIDTH-1:0] prog_data,
  input  logic                   prog_last,
  input  logic [ADDR_WIDTH-1:0]  fetch_pc,
  input  logic                   halted,
  output logic                   prog_ready,
  output logic [INSTR_WIDTH-1:0] fetch_instr,
  output logic                   run,
  output logic                   loaded
);

  localparam int PTR_W = $clog2(IMEM_DEPTH);

  logic [INSTR_WIDTH-1:0] imem [IMEM_DEPTH];
  logic [PTR_W-1:0]       load_ptr;
  logic                   accept;

  // words are only taken while the core is idle
  assign prog_ready  = ~run;
  assign accept      = prog_valid & prog_ready;
  assign fetch_instr = imem[fetch_pc[PTR_W-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run      <= 1'b0;
      loaded   <= 1'b0;
      load_ptr <= '0;
    end else if (run) begin
      if (halted) run <= 1'b0;
    end else if (accept) begin
      if (prog_last) begin
        // next program starts again at word 0
        load_ptr <= '0;
        run      <= 1'b1;
        loaded   <= 1'b1;
      end else begin
        load_ptr <= load_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) imem[load_ptr] <= prog_data;
  end

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/100ps

module decode_unit
  import cpu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [INSTR_WIDTH-1:0]    instr,
  input  logic                      wb_write,
  input  logic [REG_ADDR_WIDTH-1:0] wb_reg,
  input  logic [DATA_WIDTH-1:0]     wb_data,
  output logic [REG_ADDR_WIDTH-1:0] rs,
  output logic [REG_ADDR_WIDTH-1:0] rt,
  output logic [REG_ADDR_WIDTH-1:0] dest,
  output logic [DATA_WIDTH-1:0]     rs_data,
  output logic [DATA_WIDTH-1:0]     rt_data,
  output logic [DATA_WIDTH-1:0]     imm,
  output alu_op_t                   alu_op,
  output logic                      alu_src,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      reg_write,
  output logic                      branch,
  output logic                      halt
);

  localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;
  localparam int IMM_BITS = IMM_MSB - IMM_LSB + 1;

  logic [DATA_WIDTH-1:0]     regs [NUM_REGS];
  opcode_t                   opcode;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic                      writes_rd;
  logic                      writes_rt;

  assign opcode = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
  assign rs     = instr[RS_MSB:RS_LSB];
  assign rt     = instr[RT_MSB:RT_LSB];
  assign rd     = instr[RD_MSB:RD_LSB];
  assign imm    = {{(DATA_WIDTH - IMM_BITS){instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};

  always_comb begin
    alu_op    = ALU_ADD;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    writes_rd = 1'b0;
    writes_rt = 1'b0;
    branch    = 1'b0;
    halt      = 1'b0;
    case (opcode)
      OP_ADD:  writes_rd = 1'b1;
      OP_SUB: begin
        alu_op    = ALU_SUB;
        writes_rd = 1'b1;
      end
      OP_AND: begin
        alu_op    = ALU_AND;
        writes_rd = 1'b1;
      end
      OP_OR: begin
        alu_op    = ALU_OR;
        writes_rd = 1'b1;
      end
      OP_SLT: begin
        alu_op    = ALU_SLT;
        writes_rd = 1'b1;
      end
      OP_ADDI: begin
        alu_src   = 1'b1;
        writes_rt = 1'b1;
      end
      OP_LW: begin
        alu_src   = 1'b1;
        mem_read  = 1'b1;
        writes_rt = 1'b1;
      end
      OP_SW: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      // compare happens in execute on forwarded operands
      OP_BEQ:  branch = 1'b1;
      OP_HALT: halt = 1'b1;
      default: ;
    endcase
  end

  assign dest      = writes_rd ? rd : rt;
  // r0 is never a destination
  assign reg_write = (writes_rd | writes_rt) & (dest != '0);

  ////////////////////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (wb_write && wb_reg != '0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // same-cycle writeback wins over the stored value
  assign rs_data = (wb_write && wb_reg != '0 && wb_reg == rs) ? wb_data : regs[rs];
  assign rt_data = (wb_write && wb_reg != '0 && wb_reg == rt) ? wb_data : regs[rt];

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit
  import cpu_pkg::*;
(
  input  logic [REG_ADDR_WIDTH-1:0] id_rs,
  input  logic [REG_ADDR_WIDTH-1:0] id_rt,
  input  logic [REG_ADDR_WIDTH-1:0] ex_dest,
  input  logic                      ex_mem_read,
  input  logic                      ex_reg_write,
  input  logic [REG_ADDR_WIDTH-1:0] mem_dest,
  input  logic                      mem_reg_write,
  input  logic [REG_ADDR_WIDTH-1:0] wb_dest,
  input  logic                      wb_reg_write,
  input  logic [REG_ADDR_WIDTH-1:0] ex_rs,
  input  logic [REG_ADDR_WIDTH-1:0] ex_rt,
  output logic                      load_stall,
  output fwd_sel_t                  forward_a,
  output fwd_sel_t                  forward_b
);

  // newest producer first, reg_write is never set for r0
  function automatic fwd_sel_t pick(input logic [REG_ADDR_WIDTH-1:0] src);
    if (mem_reg_write && mem_dest == src) return FWD_MEM;
    if (wb_reg_write && wb_dest == src) return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb begin
    forward_a = pick(ex_rs);
    forward_b = pick(ex_rt);
  end

  // load data is not ready until writeback, so hold the consumer a cycle
  assign load_stall = ex_mem_read & ex_reg_write & ((ex_dest == id_rs) | (ex_dest == id_rt));

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit
  import cpu_pkg::*;
(
  input  alu_op_t               alu_op,
  input  logic [DATA_WIDTH-1:0] rs_data,
  input  logic [DATA_WIDTH-1:0] rt_data,
  input  logic [DATA_WIDTH-1:0] mem_result,
  input  logic [DATA_WIDTH-1:0] wb_result,
  input  logic [DATA_WIDTH-1:0] imm,
  input  fwd_sel_t              forward_a,
  input  fwd_sel_t              forward_b,
  input  logic                  alu_src,
  input  logic                  branch,
  input  logic [ADDR_WIDTH-1:0] pc,
  output logic [DATA_WIDTH-1:0] alu_result,
  output logic [DATA_WIDTH-1:0] store_data,
  output logic                  branch_taken,
  output logic [ADDR_WIDTH-1:0] branch_target
);

  logic [DATA_WIDTH-1:0] op_a;
  logic [DATA_WIDTH-1:0] op_b_reg;
  logic [DATA_WIDTH-1:0] op_b;

  function automatic logic [DATA_WIDTH-1:0] fwd_mux(input fwd_sel_t sel,
                                                    input logic [DATA_WIDTH-1:0] reg_val);
    case (sel)
      FWD_MEM: return mem_result;
      FWD_WB:  return wb_result;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a     = fwd_mux(forward_a, rs_data);
    op_b_reg = fwd_mux(forward_b, rt_data);
    op_b     = alu_src ? imm : op_b_reg;
  end

  always_comb begin
    case (alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: alu_result = DATA_WIDTH'($signed(op_a) < $signed(op_b));
      default: alu_result = op_a + op_b;
    endcase
  end

  assign store_data    = op_b_reg;
  // beq target is relative to the word after the branch
  assign branch_taken  = branch & (op_a == op_b_reg);
  assign branch_target = pc + ADDR_WIDTH'(1) + imm[ADDR_WIDTH-1:0];

endmodule

//--- rtl/pipeline_core.sv
`timescale 1ns/100ps

module pipeline_core
  import cpu_pkg::*;
#(
  parameter int DMEM_DEPTH = 64
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      run,
  input  logic [INSTR_WIDTH-1:0]    fetch_instr,
  input  logic                      room,
  output logic [ADDR_WIDTH-1:0]     fetch_pc,
  output logic                      wb_push,
  output logic [REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [DATA_WIDTH-1:0]     wb_data,
  output logic                      halted
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  // fetch control
  logic [ADDR_WIDTH-1:0] pc;
  logic                  run_q;
  logic                  fetch_active;
  logic                  fetch_on;
  logic                  freeze;
  logic                  stall;
  logic                  stop_fetch;

  // if/id
  logic                   if_valid;
  logic [INSTR_WIDTH-1:0] if_instr;
  logic [ADDR_WIDTH-1:0]  if_pc;

  // decode and hazard outputs
  logic [REG_ADDR_WIDTH-1:0] id_rs, id_rt, id_dest;
  logic [DATA_WIDTH-1:0]     id_rs_data, id_rt_data, id_imm;
  alu_op_t                   id_alu_op;
  logic id_alu_src, id_mem_read, id_mem_write, id_reg_write, id_branch, id_halt;
  logic                      load_stall;
  fwd_sel_t                  forward_a, forward_b;

  // id/ex
  logic                      ex_valid;
  logic [ADDR_WIDTH-1:0]     ex_pc;
  logic [REG_ADDR_WIDTH-1:0] ex_rs, ex_rt, ex_dest;
  logic [DATA_WIDTH-1:0]     ex_rs_data, ex_rt_data, ex_imm;
  alu_op_t                   ex_alu_op;
  logic ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_branch, ex_halt;
  logic [DATA_WIDTH-1:0]     alu_result, store_data;
  logic                      branch_taken;
  logic [ADDR_WIDTH-1:0]     branch_target;

  // ex/mem and mem/wb
  logic                      mem_valid;
  logic [DATA_WIDTH-1:0]     mem_alu, mem_store;
  logic [REG_ADDR_WIDTH-1:0] mem_dest;
  logic mem_mem_read, mem_mem_write, mem_reg_write, mem_halt;
  logic [DATA_WIDTH-1:0]     dmem [DMEM_DEPTH];
  logic [DATA_WIDTH-1:0]     load_data;
  logic                      wb_valid;
  logic [DATA_WIDTH-1:0]     wb_alu, wb_load;
  logic wb_mem_read, wb_reg_write, wb_halt;

  // queue nearly full holds every stage before writeback
  assign freeze     = ~room;
  assign stall      = load_stall & if_valid;
  assign stop_fetch = if_valid & id_halt;
  // fetch at pc 0 already in the first cycle of run
  assign fetch_on   = run & (fetch_active | ~run_q);
  assign fetch_pc   = pc;

  ////////////////////////////////////////////////////////////////////////////
  // program counter and valid bits

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc           <= '0;
      run_q        <= 1'b0;
      fetch_active <= 1'b0;
    end else begin
      run_q <= run;
      if (run && !run_q) begin
        fetch_active <= 1'b1;
      end else if (stop_fetch && !freeze && !branch_taken) begin
        fetch_active <= 1'b0;
      end
      if (!fetch_on) begin
        pc <= '0;
      end else if (!freeze) begin
        if (branch_taken) begin
          pc <= branch_target;
        end else if (!stall && !stop_fetch) begin
          pc <= pc + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_valid  <= 1'b0;
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      if (!freeze) begin
        if (branch_taken) begin
          if_valid <= 1'b0;
        end else if (!stall) begin
          if_valid <= fetch_on & ~stop_fetch;
        end
        ex_valid  <= if_valid & ~stall & ~branch_taken;
        mem_valid <= ex_valid;
      end
      // writeback keeps draining into the queue
      wb_valid <= mem_valid & ~freeze;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage payloads

  always_ff @(posedge clk) begin
    if (!freeze && !stall) begin
      if_instr <= fetch_instr;
      if_pc    <= pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      ex_pc        <= if_pc;
      ex_rs        <= id_rs;
      ex_rt        <= id_rt;
      ex_dest      <= id_dest;
      ex_rs_data   <= id_rs_data;
      ex_rt_data   <= id_rt_data;
      ex_imm       <= id_imm;
      ex_alu_op    <= id_alu_op;
      ex_alu_src   <= id_alu_src;
      ex_mem_read  <= id_mem_read;
      ex_mem_write <= id_mem_write;
      ex_reg_write <= id_reg_write;
      ex_branch    <= id_branch;
      ex_halt      <= id_halt;
    end else begin
      // the retiring value is gone next cycle, so catch it while execute waits
      if (wb_push && wb_reg == ex_rs) ex_rs_data <= wb_data;
      if (wb_push && wb_reg == ex_rt) ex_rt_data <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      mem_alu       <= alu_result;
      mem_store     <= store_data;
      mem_dest      <= ex_dest;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
      mem_halt      <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_alu       <= mem_alu;
    wb_load      <= load_data;
    wb_reg       <= mem_dest;
    wb_mem_read  <= mem_mem_read;
    wb_reg_write <= mem_reg_write;
    wb_halt      <= mem_halt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // data memory and writeback

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) dmem[i] <= '0;
    end else if (mem_valid && mem_mem_write && !freeze) begin
      dmem[mem_alu[DMEM_AW-1:0]] <= mem_store;
    end
  end

  assign load_data = dmem[mem_alu[DMEM_AW-1:0]];
  assign wb_data   = wb_mem_read ? wb_load : wb_alu;
  assign wb_push   = wb_valid & wb_reg_write;
  assign halted    = wb_valid & wb_halt;

  decode_unit u_decode_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (if_instr),
    .wb_write  (wb_push),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .rs        (id_rs),
    .rt        (id_rt),
    .dest      (id_dest),
    .rs_data   (id_rs_data),
    .rt_data   (id_rt_data),
    .imm       (id_imm),
    .alu_op    (id_alu_op),
    .alu_src   (id_alu_src),
    .mem_read  (id_mem_read),
    .mem_write (id_mem_write),
    .reg_write (id_reg_write),
    .branch    (id_branch),
    .halt      (id_halt)
  );

  hazard_unit u_hazard_unit (
    .id_rs         (id_rs),
    .id_rt         (id_rt),
    .ex_dest       (ex_dest),
    .ex_mem_read   (ex_valid & ex_mem_read),
    .ex_reg_write  (ex_valid & ex_reg_write),
    .mem_dest      (mem_dest),
    .mem_reg_write (mem_valid & mem_reg_write),
    .wb_dest       (wb_reg),
    .wb_reg_write  (wb_push),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .load_stall    (load_stall),
    .forward_a     (forward_a),
    .forward_b     (forward_b)
  );

  execute_unit u_execute_unit (
    .alu_op        (ex_alu_op),
    .rs_data       (ex_rs_data),
    .rt_data       (ex_rt_data),
    .mem_result    (mem_alu),
    .wb_result     (wb_data),
    .imm           (ex_imm),
    .forward_a     (forward_a),
    .forward_b     (forward_b),
    .alu_src       (ex_alu_src),
    .branch        (ex_valid & ex_branch),
    .pc            (ex_pc),
    .alu_result    (alu_result),
    .store_data    (store_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

endmodule

//--- rtl/retire_queue.sv
`timescale 1ns/100ps

module retire_queue
  import cpu_pkg::*;
#(
  parameter int RETIRE_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_push,
  input  logic [REG_ADDR_WIDTH-1:0] wb_reg,
  input  logic [DATA_WIDTH-1:0]     wb_data,
  input  logic                      ret_ready,
  output logic                      room,
  output logic                      ret_valid,
  output logic [REG_ADDR_WIDTH-1:0] ret_reg,
  output logic [DATA_WIDTH-1:0]     ret_data
);

  localparam int PTR_W = $clog2(RETIRE_DEPTH);
  localparam int CNT_W = $clog2(RETIRE_DEPTH + 1);
  // pushes that can still arrive after room drops
  localparam int IN_FLIGHT = 3;

  logic [REG_ADDR_WIDTH-1:0] reg_mem  [RETIRE_DEPTH];
  logic [DATA_WIDTH-1:0]     data_mem [RETIRE_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          count;
  logic                      pop;

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(RETIRE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ret_valid = (count != '0);
  assign ret_reg   = reg_mem[rd_ptr];
  assign ret_data  = data_mem[rd_ptr];
  assign pop       = ret_valid & ret_ready;
  assign room      = (RETIRE_DEPTH - int'(count)) >= IN_FLIGHT;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wb_push) wr_ptr <= bump(wr_ptr);
      if (pop) rd_ptr <= bump(rd_ptr);
      count <= count + CNT_W'(wb_push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (wb_push) begin
      reg_mem[wr_ptr]  <= wb_reg;
      data_mem[wr_ptr] <= wb_data;
    end
  end

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int IMEM_DEPTH   = 64,
  parameter int DMEM_DEPTH   = 64,
  parameter int RETIRE_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      prog_valid,
  input  logic [INSTR_WIDTH-1:0]    prog_data,
  input  logic                      prog_last,
  input  logic                      ret_ready,
  output logic                      prog_ready,
  output logic                      ret_valid,
  output logic [REG_ADDR_WIDTH-1:0] ret_reg,
  output logic [DATA_WIDTH-1:0]     ret_data,
  output logic                      done
);

  logic                      run;
  logic                      loaded;
  logic                      halted;
  logic [ADDR_WIDTH-1:0]     fetch_pc;
  logic [INSTR_WIDTH-1:0]    fetch_instr;
  logic                      wb_push;
  logic [REG_ADDR_WIDTH-1:0] wb_reg;
  logic [DATA_WIDTH-1:0]     wb_data;
  logic                      room;

  // idle again after a program has run
  assign done = loaded & ~run;

  program_loader #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_program_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .prog_valid  (prog_valid),
    .prog_data   (prog_data),
    .prog_last   (prog_last),
    .fetch_pc    (fetch_pc),
    .halted      (halted),
    .prog_ready  (prog_ready),
    .fetch_instr (fetch_instr),
    .run         (run),
    .loaded      (loaded)
  );

  pipeline_core #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_pipeline_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .fetch_instr (fetch_instr),
    .room        (room),
    .fetch_pc    (fetch_pc),
    .wb_push     (wb_push),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .halted      (halted)
  );

  retire_queue #(
    .RETIRE_DEPTH (RETIRE_DEPTH)
  ) u_retire_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_push   (wb_push),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .ret_ready (ret_ready),
    .room      (room),
    .ret_valid (ret_valid),
    .ret_reg   (ret_reg),
    .ret_data  (ret_data)
  );

endmodule

//--- testbench/cpu_properties.sv
`timescale 1ns/100ps

module cpu_properties
  import cpu_pkg::*;
(
  input logic                      clk,
  input logic                      rst_n,
  input logic                      ret_valid,
  input logic                      ret_ready,
  input logic [REG_ADDR_WIDTH-1:0] ret_reg,
  input logic [DATA_WIDTH-1:0]     ret_data,
  input logic                      prog_valid,
  input logic                      prog_last,
  input logic                      prog_ready,
  input logic                      done
);

  // a stalled record holds until taken
  ret_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ret_valid && !ret_ready |=> ret_valid && $stable(ret_reg) && $stable(ret_data))
    else $error("retire record changed while stalled");

  // loading closes once the last word is taken
  prog_closed: assert property (@(posedge clk) disable iff (!rst_n)
    prog_valid && prog_ready && prog_last |=> !prog_ready && !done)
    else $error("prog_ready or done high after the last program word");

  ret_reset: assert property (@(posedge clk) $past(!rst_n) |-> !ret_valid)
    else $error("ret_valid high out of reset");

endmodule

bind cpu_top cpu_properties u_cpu_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .ret_valid  (ret_valid),
  .ret_ready  (ret_ready),
  .ret_reg    (ret_reg),
  .ret_data   (ret_data),
  .prog_valid (prog_valid),
  .prog_last  (prog_last),
  .prog_ready (prog_ready),
  .done       (done)
);

//--- testbench/cpu_checker.sv
`timescale 1ns/100ps

module cpu_checker
  import cpu_pkg::*;
(
  input logic                      clk,
  input logic                      rst_n,
  input logic                      ret_valid,
  input logic                      ret_ready,
  input logic [REG_ADDR_WIDTH-1:0] ret_reg,
  input logic [DATA_WIDTH-1:0]     ret_data,
  input logic                      done,
  input logic                      prog_ready
);

  localparam int DONE_TIMEOUT  = 500;
  localparam int DRAIN_TIMEOUT = 2000;

  logic [REG_ADDR_WIDTH-1:0] exp_reg_q [$];
  logic [DATA_WIDTH-1:0]     exp_data_q [$];
  int                        mismatch_count = 0;
  int                        fault_count = 0;
  int                        rec_idx = 0;

  task automatic expect_record(input logic [REG_ADDR_WIDTH-1:0] rg,
                               input logic [DATA_WIDTH-1:0] val);
    exp_reg_q.push_back(rg);
    exp_data_q.push_back(val);
  endtask

  // compare every retire transfer, in order
  always @(posedge clk) begin
    if (rst_n && ret_valid && ret_ready) begin
      if (exp_reg_q.size() == 0) begin
        $display("extra retire record r%0d = %h at %0t, nothing was expected",
                 ret_reg, ret_data, $time);
        fault_count++;
      end else begin
        if (ret_reg !== exp_reg_q[0] || ret_data !== exp_data_q[0]) begin
          $display("Mismatch at %0t: record %0d expected r%0d = %h, got r%0d = %h",
                   $time, rec_idx, exp_reg_q[0], exp_data_q[0], ret_reg, ret_data);
          mismatch_count++;
        end
        void'(exp_reg_q.pop_front());
        void'(exp_data_q.pop_front());
      end
      rec_idx++;
    end
  end

  task automatic wait_done;
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!done && waited < DONE_TIMEOUT);
    if (!done) begin
      $display("done never rose within %0d cycles", DONE_TIMEOUT);
      fault_count++;
    end else if (!prog_ready) begin
      $display("prog_ready did not return after done at %0t", $time);
      fault_count++;
    end
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    // expected records first, then whatever is still queued behind them
    while ((exp_reg_q.size() != 0 || ret_valid) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_reg_q.size() != 0) begin
      $display("%0d expected retire records never arrived", exp_reg_q.size());
      fault_count++;
      exp_reg_q.delete();
      exp_data_q.delete();
    end else if (ret_valid) begin
      $display("retire records still pending after the program finished");
      fault_count++;
    end
  endtask

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu
  import cpu_pkg::*;
;

  localparam int LOAD_TIMEOUT = 200;

  logic                      clk;
  logic                      rst_n;
  logic                      prog_valid;
  logic [INSTR_WIDTH-1:0]    prog_data;
  logic                      prog_last;
  logic                      ret_ready;
  logic                      prog_ready;
  logic                      ret_valid;
  logic [REG_ADDR_WIDTH-1:0] ret_reg;
  logic [DATA_WIDTH-1:0]     ret_data;
  logic                      done;

  logic                      random_ready;
  int                        load_timeouts;

  // program table, one entry per word
  logic [INSTR_WIDTH-1:0]    word_q [$];
  int                        word_prog_q [$];
  bit                        word_last_q [$];

  // expected retire records per program
  int                        exp_prog_q [$];
  logic [REG_ADDR_WIDTH-1:0] exp_reg_q [$];
  logic [DATA_WIDTH-1:0]     exp_val_q [$];

  cpu_top #(
    .IMEM_DEPTH   (64),
    .DMEM_DEPTH   (64),
    .RETIRE_DEPTH (8)
  ) u_cpu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_valid (prog_valid),
    .prog_data  (prog_data),
    .prog_last  (prog_last),
    .ret_ready  (ret_ready),
    .prog_ready (prog_ready),
    .ret_valid  (ret_valid),
    .ret_reg    (ret_reg),
    .ret_data   (ret_data),
    .done       (done)
  );

  cpu_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .ret_valid  (ret_valid),
    .ret_ready  (ret_ready),
    .ret_reg    (ret_reg),
    .ret_data   (ret_data),
    .done       (done),
    .prog_ready (prog_ready)
  );

  always #2 clk = ~clk;

  // ready is random only in the back-pressure phase
  always @(posedge clk) begin
    #0.5;
    ret_ready = random_ready ? (($urandom % 3) == 0) : 1'b1;
  end

  function automatic logic [INSTR_WIDTH-1:0] rtype(input opcode_t op, input logic [4:0] rs,
                                                   input logic [4:0] rt, input logic [4:0] rd);
    return {op, rs, rt, rd, 11'b0};
  endfunction

  function automatic logic [INSTR_WIDTH-1:0] itype(input opcode_t op, input logic [4:0] rs,
                                                   input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic add_word(input int prog, input logic [INSTR_WIDTH-1:0] word, input bit last);
    word_q.push_back(word);
    word_prog_q.push_back(prog);
    word_last_q.push_back(last);
  endtask

  task automatic add_record(input int prog, input logic [4:0] rg, input logic [31:0] val);
    exp_prog_q.push_back(prog);
    exp_reg_q.push_back(rg);
    exp_val_q.push_back(val);
  endtask

  task automatic build_tables;
    // program 1: forwarding chain, store/load, branches, r0 writes
    add_word(1, itype(OP_ADDI, 0, 1, 16'd5), 0);
    add_word(1, itype(OP_ADDI, 1, 2, 16'd3), 0);
    add_word(1, rtype(OP_ADD, 1, 2, 3), 0);
    add_word(1, rtype(OP_SUB, 3, 1, 4), 0);
    add_word(1, rtype(OP_AND, 4, 3, 5), 0);
    add_word(1, rtype(OP_OR, 5, 1, 6), 0);
    add_word(1, rtype(OP_SLT, 1, 2, 7), 0);
    add_word(1, itype(OP_SW, 0, 3, 16'd4), 0);
    add_word(1, itype(OP_LW, 0, 8, 16'd4), 0);
    add_word(1, rtype(OP_ADD, 8, 1, 9), 0);
    add_word(1, itype(OP_BEQ, 2, 4, 16'd2), 0);
    add_word(1, itype(OP_ADDI, 0, 10, 16'd99), 0);
    add_word(1, itype(OP_ADDI, 0, 11, 16'd77), 0);
    add_word(1, itype(OP_BEQ, 1, 2, 16'd2), 0);
    add_word(1, itype(OP_ADDI, 0, 0, 16'd7), 0);
    add_word(1, rtype(OP_ADD, 0, 1, 12), 0);
    add_word(1, {OP_HALT, 26'd0}, 1);
    add_record(1, 1, 5);
    add_record(1, 2, 8);
    add_record(1, 3, 13);
    add_record(1, 4, 8);
    add_record(1, 5, 8);
    add_record(1, 6, 13);
    add_record(1, 7, 1);
    add_record(1, 8, 13);
    add_record(1, 9, 18);
    add_record(1, 12, 5);
    // program 2: builds on registers and memory left by program 1
    add_word(2, rtype(OP_ADD, 3, 12, 13), 0);
    add_word(2, itype(OP_ADDI, 13, 14, 16'd1), 0);
    add_word(2, itype(OP_ADDI, 14, 15, 16'd2), 0);
    add_word(2, itype(OP_ADDI, 15, 16, 16'd3), 0);
    add_word(2, rtype(OP_SUB, 16, 13, 17), 0);
    add_word(2, itype(OP_LW, 0, 18, 16'd4), 0);
    add_word(2, rtype(OP_ADD, 18, 17, 19), 0);
    add_word(2, rtype(OP_OR, 19, 7, 20), 0);
    add_word(2, rtype(OP_SLT, 17, 1, 21), 0);
    add_word(2, itype(OP_ADDI, 21, 22, 16'hffff), 0);
    add_word(2, rtype(OP_SLT, 22, 0, 23), 0);
    add_word(2, rtype(OP_AND, 22, 16, 24), 0);
    add_word(2, itype(OP_ADDI, 24, 25, 16'd100), 0);
    add_word(2, {OP_HALT, 26'd0}, 1);
    add_record(2, 13, 18);
    add_record(2, 14, 19);
    add_record(2, 15, 21);
    add_record(2, 16, 24);
    add_record(2, 17, 6);
    add_record(2, 18, 13);
    add_record(2, 19, 19);
    add_record(2, 20, 19);
    add_record(2, 21, 0);
    add_record(2, 22, 32'hffff_ffff);
    add_record(2, 23, 1);
    add_record(2, 24, 24);
    add_record(2, 25, 124);
  endtask

  task automatic load_program(input int prog);
    int waited;
    for (int i = 0; i < word_q.size(); i++) begin
      if (word_prog_q[i] != prog) continue;
      prog_valid = 1'b1;
      prog_data  = word_q[i];
      prog_last  = word_last_q[i];
      waited     = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!prog_ready && waited < LOAD_TIMEOUT);
      if (!prog_ready) begin
        $display("loader never accepted word %0d of program %0d", i, prog);
        load_timeouts++;
      end
      #0.5;
    end
    prog_valid = 1'b0;
    prog_last  = 1'b0;
  endtask

  initial begin
    int total;
    void'($urandom(32'h264bb08b));
    clk           = 1'b0;
    rst_n         = 1'b0;
    prog_valid    = 1'b0;
    prog_data     = '0;
    prog_last     = 1'b0;
    ret_ready     = 1'b1;
    random_ready  = 1'b0;
    load_timeouts = 0;
    build_tables();
    repeat (16) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    for (int prog = 1; prog <= 2; prog++) begin
      for (int i = 0; i < exp_prog_q.size(); i++) begin
        if (exp_prog_q[i] == prog) u_checker.expect_record(exp_reg_q[i], exp_val_q[i]);
      end
      load_program(prog);
      u_checker.wait_done();
      u_checker.wait_drain();
      // later programs run with back-pressure on the retire port
      random_ready = 1'b1;
      #0.5;
    end

    total = u_checker.mismatch_count + u_checker.fault_count + load_timeouts;
    $display("errors: mismatches %0d, missing/extra/done faults %0d, load timeouts %0d",
             u_checker.mismatch_count, u_checker.fault_count, load_timeouts);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
rtl/cpu_pkg.sv
rtl/program_loader.sv
rtl/decode_unit.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/pipeline_core.sv
rtl/retire_queue.sv
rtl/cpu_top.sv
testbench/cpu_properties.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
  -f all.f -Mdir obj_dir -o sim_cpu
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
